// ==== all.f ====
common/axi_rd_pkg.sv
axi_read/axi_read_master.sv
axi_read/read_mask_stage.sv
src/axi_read_top.sv
tests/axi_slave_model.sv
tests/tb_axi_read.sv

// ==== axi_read/axi_read_master.sv ====
module axi_read_master
	import axi_rd_pkg::*;
(
	input  logic    clk,
	input  logic    reset_n,

	// CPU request
	input  logic    req_valid_i,
	input  rd_req_t req_i,
	output logic    req_ready_o,

	// AXI AR channel
	output logic    ar_valid_o,
	output axi_ar_t ar_o,
	input  logic    ar_ready_i,

	// AXI R channel
	input  logic    r_valid_i,
	input  axi_r_t  r_i,
	output logic    r_ready_o,

	// Accepted beat to the mask stage
	output logic    beat_valid_o,
	output beat_t   beat_o
);

	rd_state_e state_q;
	rd_state_e state_d;

	logic req_fire;
	logic ar_fire;
	logic r_fire;
	logic r_done;

	logic [2:0]          axsize;
	logic [ADDR_W-1:0]   aligned_addr;
	axi_ar_t             ar_q;
	access_size_e        size_q;
	logic [OFFSET_W-1:0] offset_q;

	assign req_fire = req_valid_i & req_ready_o;
	assign ar_fire  = ar_valid_o & ar_ready_i;
	assign r_fire   = r_valid_i & r_ready_o;
	assign r_done   = r_fire & r_i.last; // Burst ends on the last beat

	// Strobes decoded from state, one burst in flight
	assign req_ready_o = (state_q == RD_IDLE);
	assign ar_valid_o  = (state_q == RD_ADDR);
	assign r_ready_o   = (state_q == RD_DATA);

	always_comb begin
		state_d = state_q;
		case (state_q)
			RD_IDLE: begin
				if (req_fire) begin
					state_d = RD_ADDR;
				end
			end
			RD_ADDR: begin
				if (ar_fire) begin
					state_d = RD_DATA;
				end
			end
			RD_DATA: begin
				if (r_done) begin
					state_d = RD_IDLE;
				end
			end
			default: begin
				state_d = RD_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state_q <= RD_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// CPU size to AxSIZE
	always_comb begin
		case (req_i.size)
			BYTE:    axsize = 3'd0; // 1 byte
			HALF:    axsize = 3'd1; // 2 bytes
			WORD:    axsize = 3'd2; // 4 bytes
			DWORD:   axsize = 3'd3; // 8 bytes
			default: axsize = 3'd0;
		endcase
	end

	assign aligned_addr = {req_i.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

	// AR fields captured at acceptance and held through RD_ADDR
	always_ff @(posedge clk) begin
		if (req_fire) begin
			ar_q.id    <= req_i.id;
			ar_q.addr  <= aligned_addr;
			ar_q.len   <= req_i.len;
			ar_q.size  <= axsize;
			ar_q.burst <= INCR;
		end
	end

	// Mask context, same for every beat of the burst
	always_ff @(posedge clk) begin
		if (req_fire) begin
			size_q   <= req_i.size;
			offset_q <= req_i.addr[OFFSET_W-1:0];
		end
	end

	assign ar_o = ar_q;

	// Raw beat plus latched context
	always_comb begin
		beat_o.data   = r_i.data;
		beat_o.resp   = r_i.resp;
		beat_o.id     = r_i.id;
		beat_o.last   = r_i.last;
		beat_o.size   = size_q;
		beat_o.offset = offset_q;
	end

	assign beat_valid_o = r_fire;

endmodule

// ==== axi_read/read_mask_stage.sv ====
module read_mask_stage
	import axi_rd_pkg::*;
(
	input  logic    clk,
	input  logic    reset_n,
	input  logic    beat_valid_i,
	input  beat_t   beat_i,
	output logic    rsp_valid_o,
	output rd_rsp_t rsp_o
);

	logic [BEAT_BYTES-1:0] lane_run;
	logic [BEAT_BYTES-1:0] lane_mask;
	logic [DATA_W-1:0]     bit_mask;
	logic                  rsp_valid_q;
	rd_rsp_t               rsp_q;

	// Run of lanes starting at lane 0
	always_comb begin
		case (beat_i.size)
			BYTE:    lane_run = BEAT_BYTES'(8'h01);
			HALF:    lane_run = BEAT_BYTES'(8'h03);
			WORD:    lane_run = BEAT_BYTES'(8'h0f);
			DWORD:   lane_run = '1;
			default: lane_run = '1;
		endcase
	end

	// Lanes past byte 7 fall off the top
	assign lane_mask = lane_run << beat_i.offset;

	always_comb begin
		for (int i = 0; i < BEAT_BYTES; i++) begin
			bit_mask[8*i +: 8] = {8{lane_mask[i]}}; // 8 bits per lane
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			rsp_valid_q <= 1'b0;
		end else begin
			rsp_valid_q <= beat_valid_i; // One cycle per beat
		end
	end

	always_ff @(posedge clk) begin
		if (beat_valid_i) begin
			rsp_q.data <= beat_i.data & bit_mask;
			rsp_q.resp <= beat_i.resp;
			rsp_q.id   <= beat_i.id;
			rsp_q.last <= beat_i.last;
		end
	end

	assign rsp_valid_o = rsp_valid_q;
	assign rsp_o       = rsp_q;

endmodule

// ==== common/axi_rd_pkg.sv ====
package axi_rd_pkg;

	localparam int DATA_W     = 64; // Bus data width
	localparam int ADDR_W     = 64;
	localparam int ID_W       = 4;
	localparam int LEN_W      = 8;  // AXI4 burst length field
	localparam int OFFSET_W   = 3;  // Byte offset within a beat
	localparam int BEAT_BYTES = 8;

	// CPU access size
	typedef enum logic [1:0] {
		BYTE  = 2'b00,
		HALF  = 2'b01,
		WORD  = 2'b10,
		DWORD = 2'b11
	} access_size_e;

	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_e;

	typedef enum logic [1:0] {
		FIXED = 2'b00,
		INCR  = 2'b01,
		WRAP  = 2'b10
	} axi_burst_e;

	// Read master FSM
	typedef enum logic [1:0] {
		RD_IDLE = 2'b00,
		RD_ADDR = 2'b01, // AR valid, waiting for ready
		RD_DATA = 2'b10  // Taking R beats until last
	} rd_state_e;

	// Request from the CPU
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr; // Byte address, not aligned
		logic [LEN_W-1:0]  len;  // Beats minus one
		access_size_e      size;
	} rd_req_t;

	// One beat back to the CPU
	typedef struct packed {
		logic [DATA_W-1:0] data; // Masked, not shifted
		axi_resp_e         resp;
		logic [ID_W-1:0]   id;
		logic              last;
	} rd_rsp_t;

	// AR channel payload
	typedef struct packed {
		logic [ID_W-1:0]   id;
		logic [ADDR_W-1:0] addr;
		logic [LEN_W-1:0]  len;
		logic [2:0]        size; // AxSIZE code
		axi_burst_e        burst;
	} axi_ar_t;

	// R channel payload
	typedef struct packed {
		logic [DATA_W-1:0] data;
		axi_resp_e         resp;
		logic              last;
		logic [ID_W-1:0]   id;
	} axi_r_t;

	// Accepted R beat plus the request context needed for masking
	typedef struct packed {
		logic [DATA_W-1:0]   data;
		axi_resp_e           resp;
		logic [ID_W-1:0]     id;
		logic                last;
		access_size_e        size;
		logic [OFFSET_W-1:0] offset;
	} beat_t;

endpackage

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_axi_read \
	--Mdir obj_dir -o tb_axi_read &&
./obj_dir/tb_axi_read > sim.log 2>&1 ||
echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== src/axi_read_top.sv ====
module axi_read_top
	import axi_rd_pkg::*;
(
	input  logic    clk,
	input  logic    reset_n,

	// CPU side
	input  logic    req_valid_i,
	input  rd_req_t req_i,
	output logic    req_ready_o,
	output logic    rsp_valid_o,
	output rd_rsp_t rsp_o,

	// AXI read address
	output logic    ar_valid_o,
	output axi_ar_t ar_o,
	input  logic    ar_ready_i,

	// AXI read data
	input  logic    r_valid_i,
	input  axi_r_t  r_i,
	output logic    r_ready_o
);

	logic  beat_valid;
	beat_t beat;

	axi_read_master i_master (
		.clk          (clk),
		.reset_n      (reset_n),
		.req_valid_i  (req_valid_i),
		.req_i        (req_i),
		.req_ready_o  (req_ready_o),
		.ar_valid_o   (ar_valid_o),
		.ar_o         (ar_o),
		.ar_ready_i   (ar_ready_i),
		.r_valid_i    (r_valid_i),
		.r_i          (r_i),
		.r_ready_o    (r_ready_o),
		.beat_valid_o (beat_valid),
		.beat_o       (beat)
	);

	// Response registered one cycle after the beat
	read_mask_stage i_mask (
		.clk          (clk),
		.reset_n      (reset_n),
		.beat_valid_i (beat_valid),
		.beat_i       (beat),
		.rsp_valid_o  (rsp_valid_o),
		.rsp_o        (rsp_o)
	);

endmodule

// ==== tests/axi_slave_model.sv ====
module axi_slave_model
	import axi_rd_pkg::*;
(
	input  logic    clk,
	input  logic    reset_n,
	input  logic    stall_en_i, // Random AR and R stalls when high
	input  logic    ar_valid_i,
	input  axi_ar_t ar_i,
	output logic    ar_ready_o,
	output logic    r_valid_o,
	output axi_r_t  r_o,
	input  logic    r_ready_i
);
	timeunit 1ns;
	timeprecision 1ps;

	logic [15:0]      lfsr;
	logic             busy; // Burst accepted, beats pending
	axi_ar_t          ar_q;
	logic [LEN_W-1:0] beat_idx;

	// Fixed mix of the whole aligned address
	function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] w);
		return (w * 64'h9e37_79b9_7f4a_7c15) ^ {w[31:0], w[63:32]};
	endfunction

	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic take_bit(output logic b);
		b = lfsr[0] & stall_en_i;
		lfsr = lfsr_step(lfsr);
	endtask

	initial begin
		logic ar_hs;
		logic r_hs;
		logic stall;
		lfsr = 16'd40;
		busy = 1'b0;
		beat_idx = '0;
		ar_q = '0;
		ar_ready_o = 1'b0;
		r_valid_o = 1'b0;
		r_o = '0;
		forever begin
			@(posedge clk);
			ar_hs = ar_valid_i & ar_ready_o;
			r_hs = r_valid_o & r_ready_i;
			if (!reset_n) begin
				busy = 1'b0;
			end else if (ar_hs) begin
				ar_q = ar_i;
				busy = 1'b1;
				beat_idx = '0;
			end else if (r_hs) begin
				if (beat_idx == ar_q.len) begin
					busy = 1'b0;
				end else begin
					beat_idx++;
				end
			end
			#1;
			take_bit(stall);
			ar_ready_o = reset_n & !busy & !stall;
			if (!reset_n) begin
				r_valid_o = 1'b0;
			end else if (!(r_valid_o && !r_hs)) begin // A valid beat stays until taken
				take_bit(stall);
				r_valid_o = busy & !stall;
				r_o.data = fill_word(ar_q.addr + {53'd0, beat_idx, 3'd0});
				r_o.resp = ar_q.addr[63] ? SLVERR : OKAY;
				r_o.last = (beat_idx == ar_q.len);
				r_o.id = ar_q.id;
			end
		end
	end

endmodule

// ==== tests/tb_axi_read.sv ====
module tb_axi_read
	import axi_rd_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int REQ_LIMIT      = 300;
	localparam int BEAT_LIMIT     = 9;
	localparam int STALL_LIMIT    = 4;
	localparam int TIMEOUT_CYCLES = REQ_LIMIT * (BEAT_LIMIT + STALL_LIMIT * 10) + 100;

	logic    clk;
	logic    reset_n;
	logic    stall_en;
	logic    req_valid;
	rd_req_t req;
	logic    req_ready;
	logic    rsp_valid;
	rd_rsp_t rsp;
	logic    ar_valid;
	axi_ar_t ar;
	logic    ar_ready;
	logic    r_valid;
	axi_r_t  r;
	logic    r_ready;

	rd_rsp_t exp_rsp_q[$];
	string   rsp_name_q[$];
	axi_ar_t exp_ar_q[$];
	string   ar_name_q[$];
	int      mismatches = 0;
	int      other_errors = 0;
	int      req_count = 0;
	int      cycle_count = 0;
	logic    in_flight = 1'b0;
	logic    ar_done = 1'b0;

	axi_read_top i_dut (
		.clk(clk), .reset_n(reset_n),
		.req_valid_i(req_valid), .req_i(req), .req_ready_o(req_ready),
		.rsp_valid_o(rsp_valid), .rsp_o(rsp),
		.ar_valid_o(ar_valid), .ar_o(ar), .ar_ready_i(ar_ready),
		.r_valid_i(r_valid), .r_i(r), .r_ready_o(r_ready)
	);

	axi_slave_model i_slave (
		.clk(clk), .reset_n(reset_n), .stall_en_i(stall_en),
		.ar_valid_i(ar_valid), .ar_i(ar), .ar_ready_o(ar_ready),
		.r_valid_o(r_valid), .r_o(r), .r_ready_i(r_ready)
	);

	always #5 clk = ~clk;

	function automatic logic [DATA_W-1:0] mem_word(input logic [ADDR_W-1:0] w);
		return (w * 64'h9e37_79b9_7f4a_7c15) ^ {w[31:0], w[63:32]};
	endfunction

	// log2 of the bytes in one access
	function automatic logic [2:0] size_code(input access_size_e s);
		case (s)
			BYTE:    return 3'd0;
			HALF:    return 3'd1;
			WORD:    return 3'd2;
			default: return 3'd3;
		endcase
	endfunction

	function automatic axi_ar_t expect_ar(input rd_req_t q);
		axi_ar_t a;
		a.id = q.id;
		a.addr = q.addr & ~64'h7;
		a.len = q.len;
		a.size = size_code(q.size);
		a.burst = INCR;
		return a;
	endfunction

	function automatic rd_rsp_t expect_beat(input rd_req_t q, input int k);
		rd_rsp_t e;
		logic [DATA_W-1:0] m;
		int nbytes;
		int off;
		nbytes = 1 << int'(size_code(q.size));
		off = int'(q.addr[2:0]);
		m = '0;
		for (int i = 0; i < BEAT_BYTES; i++) begin
			if (i >= off && i < off + nbytes) begin
				m[8*i +: 8] = 8'hff; // Lanes past byte 7 never selected
			end
		end
		e.data = mem_word((q.addr & ~64'h7) + (64'(k) << 3)) & m;
		e.resp = q.addr[63] ? SLVERR : OKAY;
		e.id = q.id;
		e.last = (k == int'(q.len));
		return e;
	endfunction

	task automatic check_rsp(input string name, input rd_rsp_t e, input rd_rsp_t a);
		if (a !== e) begin
			mismatches++;
			// data/resp/id/last
			$display("MISMATCH %s rsp: expected %h/%0d/%h/%b, actual %h/%0d/%h/%b",
				name, e.data, e.resp, e.id, e.last, a.data, a.resp, a.id, a.last);
		end
	endtask

	task automatic check_ar(input string name, input axi_ar_t e, input axi_ar_t a);
		if (a !== e) begin
			mismatches++;
			$display("MISMATCH %s ar: expected %h, actual %h", name, e, a);
		end
	endtask

	task automatic check_flag(input string name, input logic e, input logic a);
		if (a !== e) begin
			mismatches++;
			$display("MISMATCH %s: expected %b, actual %b", name, e, a);
		end
	endtask

	// Compares every AR and response against the expected queues
	always @(posedge clk) begin
		if (reset_n) begin
			if (rsp_valid) begin
				if (exp_rsp_q.size() == 0) begin
					other_errors++;
					$display("Response with id %h arrived with nothing outstanding", rsp.id);
				end else begin
					check_rsp(rsp_name_q.pop_front(), exp_rsp_q.pop_front(), rsp);
				end
				if (rsp.last) begin
					in_flight = 1'b0;
				end
			end
			if (in_flight && req_ready) begin
				other_errors++;
				$display("Request ready went high while a burst was in progress");
			end
			if (ar_valid && (ar_done || !in_flight)) begin
				other_errors++;
				$display("AR valid high with no request waiting for its address, address %h",
					ar.addr);
			end else if (ar_valid && ar_ready) begin
				if (exp_ar_q.size() == 0) begin
					other_errors++;
					$display("Extra AR transfer to address %h", ar.addr);
				end else begin
					check_ar(ar_name_q.pop_front(), exp_ar_q.pop_front(), ar);
				end
				ar_done = 1'b1;
			end
			if (r_ready && !(in_flight && ar_done)) begin
				other_errors++;
				$display("R ready high outside the data phase of a burst");
			end
			if (req_valid && req_ready) begin
				in_flight = 1'b1;
				ar_done = 1'b0;
			end
		end
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles with %0d responses still expected",
				cycle_count, exp_rsp_q.size());
			$display("Finished with errors");
			$finish;
		end
	end

	task automatic send_req(input string name, input rd_req_t q);
		exp_ar_q.push_back(expect_ar(q));
		ar_name_q.push_back(name);
		for (int k = 0; k <= int'(q.len); k++) begin
			exp_rsp_q.push_back(expect_beat(q, k));
			rsp_name_q.push_back(name);
		end
		req = q;
		req_valid = 1'b1;
		do begin
			@(posedge clk);
		end while (!req_ready);
		#1;
		req_valid = 1'b0;
		req_count++;
	endtask

	// Every size at every offset with one beat each
	task automatic run_single(input string name);
		rd_req_t q;
		for (int s = 0; s < 4; s++) begin
			for (int off = 0; off < BEAT_BYTES; off++) begin
				q.id = ID_W'(req_count);
				q.addr = 64'h1_0000 + 64'(req_count * 64 + off);
				q.len = '0;
				q.size = access_size_e'(2'(s));
				send_req(name, q);
			end
		end
	endtask

	task automatic run_burst(input string name, input logic err_odd);
		rd_req_t q;
		for (int ln = 0; ln < 8; ln++) begin
			q.id = ID_W'(req_count);
			q.addr = 64'h20_0000 + 64'(req_count * 256 + ln);
			q.addr[63] = err_odd & ln[0]; // Odd lengths answer SLVERR
			q.len = LEN_W'(ln);
			q.size = access_size_e'(2'(ln));
			send_req(name, q);
		end
	endtask

	task automatic drain();
		while (exp_rsp_q.size() != 0) begin
			@(posedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		stall_en = 1'b0;
		req_valid = 1'b0;
		req = '0;
		repeat (5) @(posedge clk);
		#1;
		reset_n = 1'b1;
		check_flag("reset req_ready_o", 1'b1, req_ready);
		check_flag("reset ar_valid_o", 1'b0, ar_valid);
		check_flag("reset r_ready_o", 1'b0, r_ready);
		check_flag("reset rsp_valid_o", 1'b0, rsp_valid);
		run_single("single");
		run_burst("burst", 1'b0);
		run_burst("slverr", 1'b1);
		drain();
		stall_en = 1'b1;
		run_single("stall_single");
		run_burst("stall_burst", 1'b0);
		run_burst("stall_slverr", 1'b1);
		drain();
		if (exp_ar_q.size() != 0) begin
			other_errors++;
			$display("%0d AR transfers never appeared", exp_ar_q.size());
		end
		$display("Requests %0d, mismatches %0d, other errors %0d",
			req_count, mismatches, other_errors);
		if (mismatches == 0 && other_errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
